// File: Makefile
# Verilator build and run for the four-channel FIFO bank

VERILATOR  ?= verilator
TOP        := tb_fifo_bank
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --assert --timing
RUN_FLAGS  := +verilator+error+limit+1000
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/fifo_bank_asserts.sv
/*
 * Bound checks on the write path: flag ordering, reset state,
 * drain gating of out_valid and overflow only on a full channel.
 */
module fifo_bank_asserts (
   input logic                               clk,
   input logic                               rst,
   input logic                               drain_en,
   input logic                               out_valid,
   input logic [chan_fifo_pkg::NUM_CHAN-1:0] overflow,
   input logic [chan_fifo_pkg::NUM_CHAN-1:0] full,
   input logic [chan_fifo_pkg::NUM_CHAN-1:0] alm_full
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0;   // read by the testbench at the end

   full_has_alm_full: assert property (
      @(posedge clk) disable iff (rst) (full & ~alm_full) == '0
   ) else begin
      fail_cnt++;
      $error("full set without alm_full, full=%b alm_full=%b", full, alm_full);
   end

   // first cycle once rst has dropped
   quiet_after_reset: assert property (
      @(posedge clk) ($past(rst) && !rst) |-> (!out_valid && overflow == '0 && full == '0)
   ) else begin
      fail_cnt++;
      $error("outputs active right after reset, out_valid=%b overflow=%b full=%b",
             out_valid, overflow, full);
   end

   // grant needs drain_en, output lands two cycles later
   valid_needs_drain: assert property (
      @(posedge clk) disable iff (rst)
         out_valid |-> ($past(drain_en, 1) || $past(drain_en, 2))
   ) else begin
      fail_cnt++;
      $error("out_valid with drain_en low for the two cycles before");
   end

   overflow_needs_full: assert property (
      @(posedge clk) disable iff (rst) (overflow & ~full) == '0
   ) else begin
      fail_cnt++;
      $error("overflow on a channel that is not full, overflow=%b full=%b", overflow, full);
   end

endmodule

bind fifo_bank_top fifo_bank_asserts u_asserts (
   .clk       (clk),
   .rst       (rst),
   .drain_en  (drain_en),
   .out_valid (out_valid),
   .overflow  (overflow),
   .full      (full),
   .alm_full  (alm_full)
);

// File: bench/tb_fifo_bank.sv
/*
 * Testbench for the four-channel write path: random and directed writes
 * against per-channel reference queues, flag, overflow and round-robin checks.
 */
module tb_fifo_bank;
   timeunit 1ns;
   timeprecision 1ps;
   import chan_fifo_pkg::*;

   localparam int unsigned SEED        = 32'hfe2254d3;
   localparam int          N_RANDOM    = 150;
   localparam int          RST_CYCLES  = 4;
   localparam int          T1_CYCLES   = 3 * N_RANDOM + 64;
   localparam int          T2_CYCLES   = 64;
   localparam int          T3_CYCLES   = 64;
   localparam int          T4_CYCLES   = 64;
   localparam int          IDLE_CYCLES = 16;   // drain gives up after this long without output
   localparam int          MARGIN_NS   = 2000;
   localparam int          LIMIT_NS    = (RST_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                          + T4_CYCLES) * 10 + MARGIN_NS;

   logic                clk = 1'b0;
   logic                rst;
   logic                in_valid;
   chan_t               in_chan;
   logic [DATA_W-1:0]   in_data;
   logic                drain_en;
   logic                out_valid;
   chan_t               out_chan;
   logic [DATA_W-1:0]   out_data;
   logic [NUM_CHAN-1:0] overflow;
   logic [NUM_CHAN-1:0] full;
   logic [NUM_CHAN-1:0] alm_full;

   logic [DATA_W-1:0] ref_q [NUM_CHAN][$];   // words expected per channel
   int                occ [NUM_CHAN];        // modeled occupancy
   chan_t             chan_log [$];
   int                errors = 0;
   int                checks = 0;
   int                mark = 0;

   always #5 clk = ~clk;

   fifo_bank_top DUT (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_chan   (in_chan),
      .in_data   (in_data),
      .drain_en  (drain_en),
      .out_valid (out_valid),
      .out_chan  (out_chan),
      .out_data  (out_data),
      .overflow  (overflow),
      .full      (full),
      .alm_full  (alm_full)
   );

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic note_failure(input string what);
      $display("%0t %s", $time, what);
      errors++;
   endtask

   task automatic finish_test(input string name);
      $display("test %s done, %0d errors", name, errors - mark);
      mark = errors;
   endtask

   function automatic int pending();
      int sum;
      sum = 0;
      foreach (occ[i]) begin
         sum += occ[i];
      end
      return sum;
   endfunction

   // called on a rising edge, returns at the falling edge of the next cycle
   task automatic send(input chan_t ch, input logic [DATA_W-1:0] d);
      logic [NUM_CHAN-1:0] exp_ovf;
      exp_ovf     = '0;
      exp_ovf[ch] = (occ[ch] >= FIFO_DEPTH);   // full channel drops the word
      if (!exp_ovf[ch]) begin
         ref_q[ch].push_back(d);
         occ[ch]++;
      end
      in_valid <= 1'b1;
      in_chan  <= ch;
      in_data  <= d;
      @(posedge clk);
      in_valid <= 1'b0;
      @(negedge clk);
      compare("overflow", 32'(exp_ovf), 32'(overflow));
   endtask

   // drain until the model is empty or the output stalls
   task automatic drain_all();
      int idle;
      int last;
      idle = 0;
      @(posedge clk);
      drain_en <= 1'b1;
      last = pending();
      while (pending() != 0 && idle < IDLE_CYCLES) begin
         @(posedge clk);
         if (pending() == last) begin
            idle++;
         end else begin
            idle = 0;
            last = pending();
         end
      end
      drain_en <= 1'b0;
      repeat (4) @(posedge clk);   // room for stray words
   endtask

   // output monitor
   always @(negedge clk) begin
      logic [DATA_W-1:0] expected;
      if (!rst && out_valid) begin
         chan_log.push_back(out_chan);
         if (ref_q[out_chan].size() == 0) begin
            note_failure($sformatf("unexpected word %0h on channel %0d", out_data, out_chan));
         end else begin
            expected = ref_q[out_chan].pop_front();
            compare("out_data", expected, out_data);
            occ[out_chan]--;
         end
      end
   end

   initial begin
      #(LIMIT_NS);
      $display("timeout: tests did not finish within %0d ns", LIMIT_NS);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      chan_t               ch;
      logic [NUM_CHAN-1:0] exp_alm;
      logic [NUM_CHAN-1:0] exp_full;
      void'($urandom(SEED));
      rst      = 1'b1;
      in_valid = 1'b0;
      in_chan  = '0;
      in_data  = '0;
      drain_en = 1'b0;
      foreach (occ[i]) begin
         occ[i] = 0;
      end
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      compare("out_valid", 32'd0, 32'(out_valid));
      compare("overflow", 32'd0, 32'(overflow));
      compare("full", 32'd0, 32'(full));
      compare("alm_full", 32'd0, 32'(alm_full));
      finish_test("reset state");

      // random traffic, never past a full channel
      @(posedge clk);
      drain_en <= 1'b1;
      for (int i = 0; i < N_RANDOM; i++) begin
         @(posedge clk);
         ch = chan_t'($urandom_range(NUM_CHAN - 1));
         if ($urandom_range(3) != 0 && occ[ch] < FIFO_DEPTH) begin
            send(ch, $urandom());
         end
      end
      drain_all();
      foreach (ref_q[c]) begin
         if (ref_q[c].size() != 0) begin
            note_failure($sformatf("channel %0d still holds %0d words", c, ref_q[c].size()));
         end
      end
      finish_test("order and integrity");

      for (int i = 0; i < FIFO_DEPTH; i++) begin
         @(posedge clk);
         send(chan_t'(1), $urandom());
         @(negedge clk);   // two cycles after the strobe
         exp_alm     = '0;
         exp_full    = '0;
         exp_alm[1]  = (occ[1] >= ALMFULL_THRESH);
         exp_full[1] = (occ[1] >= FIFO_DEPTH);
         compare("alm_full", 32'(exp_alm), 32'(alm_full));
         compare("full", 32'(exp_full), 32'(full));
      end
      drain_all();
      finish_test("flag thresholds");

      // channel 3 leaves the pointer at 0 for the fairness test
      for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
         @(posedge clk);
         send(chan_t'(3), $urandom());
      end
      chan_log.delete();
      drain_all();
      compare("word count", 32'(FIFO_DEPTH), 32'(chan_log.size()));
      finish_test("overflow and drop");

      for (int r = 0; r < 3; r++) begin
         for (int c = 0; c < NUM_CHAN; c++) begin
            @(posedge clk);
            send(chan_t'(c), $urandom());
         end
      end
      chan_log.delete();
      drain_all();
      compare("word count", 32'd12, 32'(chan_log.size()));
      foreach (chan_log[i]) begin
         compare("out_chan", 32'(i % NUM_CHAN), 32'(chan_log[i]));
      end
      finish_test("round-robin order");

      $display("checks %0d, errors %0d, assertion failures %0d",
               checks, errors, DUT.u_asserts.fail_cnt);
      if (errors == 0 && DUT.u_asserts.fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: src/chan_fifo.sv
/*
 * Registered FIFO for one channel: storage array with write and read
 * pointers, occupancy count with full and almost-full, registered read port.
 */
module chan_fifo (
   input  logic       clk,
   input  logic       rst,
   chan_fifo_if.fifo  port
);
   import chan_fifo_pkg::*;

   typedef logic [DEPTH_LOG2:0]   cnt_t;
   typedef logic [DEPTH_LOG2-1:0] ptr_t;

   logic [DATA_W-1:0] mem [FIFO_DEPTH];

   ptr_t              wr_ptr;
   ptr_t              rd_ptr;
   cnt_t              count_q;
   logic [DATA_W-1:0] rd_data_q;
   logic              rd_valid_q;

   // storage, no reset needed on the array
   always_ff @(posedge clk) begin
      if (port.wr_en) begin
         mem[wr_ptr] <= port.wr_data;
      end
   end

   // pointers wrap naturally at FIFO_DEPTH
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (port.wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (port.rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // occupancy
   always_ff @(posedge clk) begin
      if (rst) begin
         count_q <= '0;
      end else begin
         case ({port.wr_en, port.rd_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;   // idle or simultaneous push/pop
         endcase
      end
   end

   // read port, data one cycle after rd_en
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= port.rd_en;
      end
   end

   always_ff @(posedge clk) begin
      if (port.rd_en) begin
         rd_data_q <= mem[rd_ptr];
      end
   end

   assign port.rd_data  = rd_data_q;
   assign port.rd_valid = rd_valid_q;

   // status from the registered count
   assign port.count    = count_q;
   assign port.full     = (count_q == cnt_t'(FIFO_DEPTH));
   assign port.alm_full = (count_q >= cnt_t'(ALMFULL_THRESH));

endmodule

// File: src/chan_fifo_if.sv
/*
 * Per-channel FIFO connection: write strobe from the steering stage,
 * read strobe from the drain arbiter, data and occupancy back from the FIFO.
 */
interface chan_fifo_if;
   import chan_fifo_pkg::*;

   logic              wr_en;
   logic [DATA_W-1:0] wr_data;
   logic              rd_en;
   logic [DATA_W-1:0] rd_data;
   logic              rd_valid;
   logic [DEPTH_LOG2:0] count;
   logic              full;
   logic              alm_full;

   modport steer (
      output wr_en, wr_data,
      input  full
   );

   modport fifo (
      input  wr_en, wr_data, rd_en,
      output rd_data, rd_valid, count, full, alm_full
   );

   modport drain (
      output rd_en,
      input  rd_data, rd_valid, count
   );

endinterface

// File: src/chan_fifo_pkg.sv
/*
 * Shared sizes and the channel-number type for the four-channel write path.
 */
package chan_fifo_pkg;

   // channel fan-out
   localparam int NUM_CHAN = 4;
   localparam int CHAN_W   = 2;   // must cover NUM_CHAN

   // payload
   localparam int DATA_W = 32;

   // per-channel buffer geometry
   localparam int DEPTH_LOG2     = 3;
   localparam int FIFO_DEPTH     = 2 ** DEPTH_LOG2;
   localparam int ALMFULL_THRESH = 6;   // occupancy where alm_full rises

   typedef logic [CHAN_W-1:0] chan_t;

endpackage

// File: src/drain_arbiter.sv
/*
 * Round-robin drain: pops one word per cycle from the non-empty FIFOs while
 * drain_en is high and registers it with its channel number.
 */
module drain_arbiter (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               drain_en,
   chan_fifo_if.drain                         fifos [chan_fifo_pkg::NUM_CHAN],
   output logic                               out_valid,
   output chan_fifo_pkg::chan_t               out_chan,
   output logic [chan_fifo_pkg::DATA_W-1:0]   out_data
);
   import chan_fifo_pkg::*;

   logic [NUM_CHAN-1:0] not_empty;
   logic [NUM_CHAN-1:0] rd_valid_v;
   logic [DATA_W-1:0]   rd_data_a [NUM_CHAN];

   chan_t             ptr;
   chan_t             gnt_chan;
   chan_t             gnt_chan_q;
   logic              gnt_hit;
   logic              grant;
   logic [DATA_W-1:0] sel_data;

   // flatten the per-channel views
   for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
      assign not_empty[i]  = (fifos[i].count != '0);
      assign rd_valid_v[i] = fifos[i].rd_valid;
      assign rd_data_a[i]  = fifos[i].rd_data;
      assign fifos[i].rd_en = grant && (gnt_chan == chan_t'(i));
   end

   // first non-empty channel at or after ptr
   always_comb begin
      chan_t cand;
      gnt_hit  = 1'b0;
      gnt_chan = ptr;
      for (int off = 0; off < NUM_CHAN; off++) begin
         cand = chan_t'((int'(ptr) + off) % NUM_CHAN);
         if (!gnt_hit && not_empty[cand]) begin
            gnt_hit  = 1'b1;
            gnt_chan = cand;
         end
      end
   end

   assign grant = drain_en && gnt_hit;

   always_ff @(posedge clk) begin
      if (rst) begin
         ptr <= '0;
      end else if (grant) begin
         ptr <= chan_t'((int'(gnt_chan) + 1) % NUM_CHAN);   // skip past winner
      end
   end

   // channel tag follows the popped word by one cycle
   always_ff @(posedge clk) begin
      gnt_chan_q <= gnt_chan;
   end

   // at most one rd_valid is high at a time
   always_comb begin
      sel_data = '0;
      for (int i = 0; i < NUM_CHAN; i++) begin
         if (rd_valid_v[i]) begin
            sel_data = rd_data_a[i];
         end
      end
   end

   // output register
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= |rd_valid_v;
      end
   end

   always_ff @(posedge clk) begin
      out_chan <= gnt_chan_q;
      out_data <= sel_data;
   end

endmodule

// File: src/fifo_bank_top.sv
/*
 * Four-channel buffered write path: steering stage, per-channel FIFOs and
 * a round-robin drain arbiter behind plain ports.
 */
module fifo_bank_top (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                in_valid,
   input  chan_fifo_pkg::chan_t                in_chan,
   input  logic [chan_fifo_pkg::DATA_W-1:0]    in_data,
   input  logic                                drain_en,
   output logic                                out_valid,
   output chan_fifo_pkg::chan_t                out_chan,
   output logic [chan_fifo_pkg::DATA_W-1:0]    out_data,
   output logic [chan_fifo_pkg::NUM_CHAN-1:0]  overflow,
   output logic [chan_fifo_pkg::NUM_CHAN-1:0]  full,
   output logic [chan_fifo_pkg::NUM_CHAN-1:0]  alm_full
);
   import chan_fifo_pkg::*;

   chan_fifo_if fifo_if [NUM_CHAN] ();

   wr_steer u_steer (
      .clk      (clk),
      .rst      (rst),
      .in_valid (in_valid),
      .in_chan  (in_chan),
      .in_data  (in_data),
      .overflow (overflow),
      .fifos    (fifo_if)
   );

   for (genvar i = 0; i < NUM_CHAN; i++) begin : g_fifo
      chan_fifo u_fifo (
         .clk  (clk),
         .rst  (rst),
         .port (fifo_if[i])
      );

      // status out as plain vectors
      assign full[i]     = fifo_if[i].full;
      assign alm_full[i] = fifo_if[i].alm_full;
   end

   drain_arbiter u_drain (
      .clk       (clk),
      .rst       (rst),
      .drain_en  (drain_en),
      .fifos     (fifo_if),
      .out_valid (out_valid),
      .out_chan  (out_chan),
      .out_data  (out_data)
   );

endmodule

// File: src/wr_steer.sv
/*
 * Write steering: registers each input strobe, routes it to its channel FIFO
 * and turns writes aimed at a full FIFO into a one-cycle overflow pulse.
 */
module wr_steer (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   in_valid,
   input  chan_fifo_pkg::chan_t                   in_chan,
   input  logic [chan_fifo_pkg::DATA_W-1:0]       in_data,
   output logic [chan_fifo_pkg::NUM_CHAN-1:0]     overflow,
   chan_fifo_if.steer                             fifos [chan_fifo_pkg::NUM_CHAN]
);
   import chan_fifo_pkg::*;

   logic              wr_valid_q;
   chan_t             wr_chan_q;
   logic [DATA_W-1:0] wr_data_q;

   // input register stage
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_valid_q <= 1'b0;
      end else begin
         wr_valid_q <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      wr_chan_q <= in_chan;
      wr_data_q <= in_data;
   end

   // one-hot decode, gated by the target's full flag
   for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
      logic hit;

      assign hit = wr_valid_q && (wr_chan_q == chan_t'(i));

      assign fifos[i].wr_en   = hit && !fifos[i].full;
      assign fifos[i].wr_data = wr_data_q;
      assign overflow[i]      = hit && fifos[i].full;   // word is dropped
   end

endmodule

// File: tb.f
src/chan_fifo_pkg.sv
src/chan_fifo_if.sv
src/wr_steer.sv
src/chan_fifo.sv
src/drain_arbiter.sv
src/fifo_bank_top.sv
bench/fifo_bank_asserts.sv
bench/tb_fifo_bank.sv
